/* all.f */
design/host_pkg.sv
design/prom_pkg.sv
design/step_timer.sv
design/frame_capture.sv
design/host_link_fsm.sv
design/job_sequencer.sv
design/supply_rails.sv
design/prom_pin_driver.sv
design/prom_programmer_top.sv
sim/tb_prom_programmer.sv

/* design/frame_capture.sv */
`timescale 1ns/1ps

module frame_capture import host_pkg::*; (
	input  logic       clk12m,
	input  logic       sense_reset,
	input  host_byte_t rx_data,
	input  logic       cap_cmd,
	input  logic       cap_arg,
	output host_byte_t cmd,
	output job_arg_u   arg
);

	always_ff @(posedge clk12m) begin
		if (sense_reset)
			cmd <= '0;
		else if (cap_cmd)
			cmd <= rx_data;
	end

	// least significant byte first, so each new byte enters at the top.
	always_ff @(posedge clk12m) begin
		if (cap_cmd)
			arg.rail_sel <= '0;
		else if (cap_arg)
			arg.rail_sel <= {rx_data, arg.rail_sel[31:8]};
	end

endmodule

/* design/host_link_fsm.sv */
`timescale 1ns/1ps

module host_link_fsm import host_pkg::*; (
	input  logic       clk12m,
	input  logic       sense_reset,
	input  host_byte_t rx_data,
	input  logic       rx_seq,
	input  logic       tx_ack,
	input  host_byte_t cmd,
	input  job_arg_u   arg,
	input  logic       job_ack,
	input  logic       job_result,
	output logic       rx_ack,
	output host_byte_t tx_data,
	output logic       tx_seq,
	output logic       cap_cmd,
	output logic       cap_arg,
	output logic       job_seq,
	output job_req_t   job_req
);

	typedef enum logic [2:0] {
		st_idle,
		st_command,
		st_arguments,
		st_process,
		st_send
	} state_t;

	state_t     state;
	logic [1:0] arg_cnt;
	host_byte_t result;
	logic       rx_pending;
	logic       job_busy;

	function automatic job_cmd_t job_of(input host_byte_t code);
		case (code)
		cmd_test_voltage: return job_test_voltage;
		cmd_config_prom:  return job_config_prom;
		cmd_pwroff:       return job_pwroff;
		default:          return job_pwron_read;
		endcase
	endfunction

	assign rx_pending = rx_seq != rx_ack;
	assign job_busy   = job_seq != job_ack;

	// bytes are stored in the same cycle they are consumed.
	assign cap_cmd = (state == st_command) && rx_pending;
	assign cap_arg = (state == st_arguments) && rx_pending;

	always_ff @(posedge clk12m) begin
		if (sense_reset) begin
			state   <= st_idle;
			arg_cnt <= '0;
			rx_ack  <= rx_seq;
			tx_seq  <= 1'b0;
			job_seq <= 1'b0;
		end else begin
			case (state)
			st_idle:
				if (rx_pending) begin
					rx_ack <= rx_seq;
					if (rx_data == sof)
						state <= st_command;
				end
			st_command:
				if (rx_pending) begin
					rx_ack  <= rx_seq;
					arg_cnt <= '0;
					state   <= st_arguments;
				end
			st_arguments:
				if (rx_pending) begin
					rx_ack  <= rx_seq;
					arg_cnt <= arg_cnt + 2'd1;
					if (arg_cnt == 2'd3)
						state <= st_process;
				end
			st_process: begin
				state <= st_send;
				// codes with bit 7 set fall through to nack.
				case (cmd)
				cmd_poll:
					if (job_busy)
						result <= result_busy;
					else
						result <= job_result ? result_ack : result_nack;
				cmd_test_voltage, cmd_config_prom, cmd_pwroff, cmd_pwron_read:
					if (job_busy) begin
						result <= result_busy;
					end else begin
						result      <= result_async;
						job_req.cmd <= job_of(cmd);
						job_req.arg <= arg;
						job_seq     <= !job_seq;
					end
				default:
					result <= result_nack;
				endcase
			end
			st_send:
				// wait for the host to take the previous byte.
				if (tx_seq == tx_ack) begin
					tx_data <= result;
					tx_seq  <= !tx_seq;
					state   <= st_idle;
				end
			default:
				state <= st_idle;
			endcase
		end
	end

endmodule

/* design/host_pkg.sv */
package host_pkg;

	typedef logic [7:0] host_byte_t;

	// ------------------------------------------------------------
	// framing and result bytes.
	// ------------------------------------------------------------
	localparam host_byte_t sof          = 8'h1b;
	localparam host_byte_t result_ack   = 8'h06;
	localparam host_byte_t result_nack  = 8'h15;
	localparam host_byte_t result_async = 8'h16;
	localparam host_byte_t result_busy  = 8'h07;

	// command codes.
	localparam host_byte_t cmd_poll         = 8'h02;
	localparam host_byte_t cmd_test_voltage = 8'h04;
	localparam host_byte_t cmd_config_prom  = 8'h05;
	localparam host_byte_t cmd_pwroff       = 8'h07;
	localparam host_byte_t cmd_pwron_read   = 8'h08;

	typedef enum logic [1:0] {
		job_test_voltage,
		job_config_prom,
		job_pwroff,
		job_pwron_read
	} job_cmd_t;

	// low bit is the 5 volt flag or the inverted reset flag.
	typedef struct packed {
		logic [30:0] spare;
		logic        flag;
	} job_flags_t;

	typedef union packed {
		job_flags_t  flags;
		logic [31:0] rail_sel;
	} job_arg_u;

	typedef struct packed {
		job_cmd_t cmd;
		job_arg_u arg;
	} job_req_t;

endpackage

/* design/job_sequencer.sv */
`timescale 1ns/1ps

module job_sequencer import host_pkg::*; import prom_pkg::*; (
	input  logic     clk12m,
	input  logic     sense_reset,
	input  logic     job_seq,
	input  job_req_t job_req,
	input  step_t    step,
	input  pmode_t   pmode,
	output logic     job_ack,
	output logic     job_result,
	output logic     step_clear,
	output logic     step_run,
	output rail_op_t rail_op,
	output pin_op_t  pin_op,
	output logic     cfg_write,
	output logic     arg_flag,
	output job_arg_u rail_sel
);

	logic     running;
	job_req_t req;
	logic     done;
	logic     done_result;

	// a new job starts with the timer at zero.
	assign step_clear = !running && (job_seq != job_ack);
	assign step_run   = running;
	assign arg_flag   = req.arg.flags.flag;
	assign rail_sel   = req.arg;

	// ------------------------------------------------------------
	// operation strobes at the step points.
	// ------------------------------------------------------------
	always_comb begin
		rail_op     = rail_op_none;
		pin_op      = pin_op_none;
		cfg_write   = 1'b0;
		done        = 1'b0;
		done_result = 1'b1;
		if (running) begin
			case (req.cmd)
			job_test_voltage: begin
				rail_op = rail_op_select_one;
				done    = 1'b1;
			end
			job_config_prom: begin
				cfg_write = 1'b1;
				done      = 1'b1;
			end
			job_pwron_read:
				if (step == step_start && pmode != pmode_off) begin
					// already powered, refuse.
					done        = 1'b1;
					done_result = 1'b0;
				end else begin
					case (step)
					step_start:     pin_op  = pin_op_read_enable;
					step_rails_on:  rail_op = rail_op_read_set;
					step_reset_on:  pin_op  = pin_op_reset_assert;
					step_read_done: begin
						pin_op = pin_op_reset_release;
						done   = 1'b1;
					end
					default: ;
					endcase
				end
			job_pwroff:
				case (step)
				step_start:     pin_op  = pin_op_park;
				step_rails_off: rail_op = rail_op_all_off;
				step_off_pulse: rail_op = rail_op_off_pulse_set;
				step_off_end:   rail_op = rail_op_off_pulse_clr;
				step_pwroff_done: begin
					pin_op = pin_op_idle;
					done   = 1'b1;
				end
				default: ;
				endcase
			default: ;
			endcase
		end
	end

	always_ff @(posedge clk12m) begin
		if (sense_reset) begin
			running    <= 1'b0;
			job_ack    <= 1'b0;
			job_result <= 1'b0;
		end else if (running) begin
			if (done) begin
				running    <= 1'b0;
				job_ack    <= job_seq;
				job_result <= done_result;
			end
		end else if (job_seq != job_ack) begin
			running <= 1'b1;
			req     <= job_req;
		end
	end

endmodule

/* design/prom_pin_driver.sv */
`timescale 1ns/1ps

module prom_pin_driver import prom_pkg::*; (
	input  logic       clk12m,
	input  logic       sense_reset,
	input  pin_op_t    pin_op,
	input  logic       arg_flag,
	output prom_pins_t pins
);

	// set when the device resets on a low level.
	logic inv_reset;

	always_ff @(posedge clk12m) begin
		if (sense_reset) begin
			pins      <= pins_idle;
			inv_reset <= 1'b0;
		end else begin
			case (pin_op)
			pin_op_idle: pins <= pins_idle;
			pin_op_read_enable: begin
				pins           <= pins_idle;
				pins.n_oe      <= 1'b0;
				pins.n_oe_ctrl <= 1'b0;
				inv_reset      <= arg_flag;
			end
			// ground these a while before the supply goes away.
			pin_op_park: begin
				pins.n_ce     <= 1'b0;
				pins.reset_oe <= 1'b0;
			end
			pin_op_reset_assert:  pins.reset_oe <= !inv_reset;
			pin_op_reset_release: pins.reset_oe <= inv_reset;
			default: ;
			endcase
		end
	end

endmodule

/* design/prom_pkg.sv */
package prom_pkg;

	localparam int ticks_per_us = 12;

	typedef logic [16:0] step_t;

	// ------------------------------------------------------------
	// step points of the power jobs.
	// ------------------------------------------------------------
	localparam step_t step_start       = '0;
	localparam step_t step_rails_on    = step_t'(4 * ticks_per_us);
	localparam step_t step_reset_on    = step_t'(1000 * ticks_per_us);
	localparam step_t step_read_done   = step_t'(6000 * ticks_per_us);
	localparam step_t step_rails_off   = step_t'(1000 * ticks_per_us);
	localparam step_t step_off_pulse   = step_t'(1005 * ticks_per_us);
	localparam step_t step_off_end     = step_t'(2000 * ticks_per_us);
	localparam step_t step_pwroff_done = step_t'(2005 * ticks_per_us);

	typedef struct packed {
		logic vcc_3v3;
		logic vcc_5v;
		logic vpp_3v3;
		logic vpp_3v7;
		logic vpp_5v;
		logic vpp_5v4;
		logic vpp_12v25;
		logic prom_off;
	} rails_t;

	typedef struct packed {
		logic n_oe;
		logic n_oe_ctrl;
		logic n_ce;
		logic reset_oe;
	} prom_pins_t;

	localparam prom_pins_t pins_idle = 4'b1100;

	typedef enum logic {
		pmode_off,
		pmode_read
	} pmode_t;

	typedef enum logic [2:0] {
		rail_op_none,
		rail_op_all_off,
		rail_op_read_set,
		rail_op_select_one,
		rail_op_off_pulse_set,
		rail_op_off_pulse_clr
	} rail_op_t;

	typedef enum logic [2:0] {
		pin_op_none,
		pin_op_idle,
		pin_op_read_enable,
		pin_op_park,
		pin_op_reset_assert,
		pin_op_reset_release
	} pin_op_t;

endpackage

/* design/prom_programmer_top.sv */
`timescale 1ns/1ps

module prom_programmer_top import host_pkg::*; import prom_pkg::*; (
	input  logic       clk12m,
	input  logic       sense_reset,
	input  host_byte_t rx_data,
	input  logic       rx_seq,
	input  logic       tx_ack,
	output logic       rx_ack,
	output host_byte_t tx_data,
	output logic       tx_seq,
	output rails_t     rails,
	output prom_pins_t pins
);

	host_byte_t cmd;
	job_arg_u   arg;
	logic       cap_cmd;
	logic       cap_arg;
	logic       job_seq;
	logic       job_ack;
	logic       job_result;
	job_req_t   job_req;
	step_t      step;
	logic       step_clear;
	logic       step_run;
	rail_op_t   rail_op;
	pin_op_t    pin_op;
	logic       cfg_write;
	logic       arg_flag;
	job_arg_u   rail_sel;
	pmode_t     pmode;

	// ------------------------------------------------------------
	// host side.
	// ------------------------------------------------------------
	host_link_fsm link (
		.clk12m, .sense_reset,
		.rx_data, .rx_seq, .tx_ack, .cmd, .arg, .job_ack, .job_result,
		.rx_ack, .tx_data, .tx_seq, .cap_cmd, .cap_arg, .job_seq, .job_req
	);

	frame_capture capture (
		.clk12m, .sense_reset,
		.rx_data, .cap_cmd, .cap_arg,
		.cmd, .arg
	);

	// ------------------------------------------------------------
	// power sequencing.
	// ------------------------------------------------------------
	job_sequencer sequencer (
		.clk12m, .sense_reset,
		.job_seq, .job_req, .step, .pmode,
		.job_ack, .job_result, .step_clear, .step_run,
		.rail_op, .pin_op, .cfg_write, .arg_flag, .rail_sel
	);

	step_timer timer (
		.clk12m, .sense_reset,
		.step_clear, .step_run,
		.step
	);

	supply_rails supplies (
		.clk12m, .sense_reset,
		.rail_op, .rail_sel, .arg_flag, .cfg_write,
		.rails, .pmode
	);

	prom_pin_driver pin_driver (
		.clk12m, .sense_reset,
		.pin_op, .arg_flag,
		.pins
	);

endmodule

/* design/step_timer.sv */
`timescale 1ns/1ps

module step_timer import prom_pkg::*; (
	input  logic  clk12m,
	input  logic  sense_reset,
	input  logic  step_clear,
	input  logic  step_run,
	output step_t step
);

	// holds at the top count instead of wrapping.
	always_ff @(posedge clk12m) begin
		if (sense_reset || step_clear)
			step <= '0;
		else if (step_run && step != '1)
			step <= step + step_t'(1);
	end

endmodule

/* design/supply_rails.sv */
`timescale 1ns/1ps

module supply_rails import host_pkg::*; import prom_pkg::*; (
	input  logic     clk12m,
	input  logic     sense_reset,
	input  rail_op_t rail_op,
	input  job_arg_u rail_sel,
	input  logic     arg_flag,
	input  logic     cfg_write,
	output rails_t   rails,
	output pmode_t   pmode
);

	logic dev_5v;

	// index 1 to 8 in struct order, everything else selects nothing.
	function automatic rails_t select_rail(input logic [31:0] sel);
		rails_t r;
		r = '0;
		case (sel)
		32'd1: r.vcc_3v3   = 1'b1;
		32'd2: r.vcc_5v    = 1'b1;
		32'd3: r.vpp_3v3   = 1'b1;
		32'd4: r.vpp_3v7   = 1'b1;
		32'd5: r.vpp_5v    = 1'b1;
		32'd6: r.vpp_5v4   = 1'b1;
		32'd7: r.vpp_12v25 = 1'b1;
		32'd8: r.prom_off  = 1'b1;
		default: ;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk12m) begin
		if (sense_reset) begin
			rails  <= '0;
			pmode  <= pmode_off;
			dev_5v <= 1'b0;
		end else begin
			if (cfg_write)
				dev_5v <= arg_flag;
			case (rail_op)
			rail_op_all_off: begin
				rails <= '0;
				pmode <= pmode_off;
			end
			rail_op_read_set: begin
				if (dev_5v) begin
					rails.vcc_5v <= 1'b1;
					rails.vpp_5v <= 1'b1;
				end else begin
					rails.vcc_3v3 <= 1'b1;
					rails.vpp_3v3 <= 1'b1;
				end
				pmode <= pmode_read;
			end
			// all rails drop first, then the selected one comes up.
			rail_op_select_one: begin
				rails <= select_rail(rail_sel.rail_sel);
				pmode <= pmode_off;
			end
			rail_op_off_pulse_set: rails.prom_off <= 1'b1;
			rail_op_off_pulse_clr: rails.prom_off <= 1'b0;
			default: ;
			endcase
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the PROM programmer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f all.f --top-module tb_prom_programmer -o tb_prom_programmer
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_prom_programmer
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

/* sim/tb_prom_programmer.sv */
`timescale 1ns/1ps

module tb_prom_programmer import host_pkg::*; import prom_pkg::*; ();

	typedef struct packed {
		host_byte_t  cmd;
		logic [31:0] arg;
		host_byte_t  reply;
		host_byte_t  poll;
		rails_t      rails;
		prom_pins_t  pins;
		logic        long_job;
	} row_t;

	localparam int n_rows = 19;

	// expected rails are one-hot in struct order, vcc_3v3 at the top bit.
	row_t rows [n_rows] = '{
		'{8'h7f, 32'h0, result_nack, result_nack, 8'h00, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd1, result_async, result_ack, 8'h80, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd2, result_async, result_ack, 8'h40, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd3, result_async, result_ack, 8'h20, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd4, result_async, result_ack, 8'h10, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd5, result_async, result_ack, 8'h08, 4'hc, 1'b0},
		'{8'h81, 32'h1234_5678, result_nack, result_ack, 8'h08, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd6, result_async, result_ack, 8'h04, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd7, result_async, result_ack, 8'h02, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd8, result_async, result_ack, 8'h01, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'd9, result_async, result_ack, 8'h00, 4'hc, 1'b0},
		'{cmd_test_voltage, 32'h103, result_async, result_ack, 8'h00, 4'hc, 1'b0},
		'{cmd_config_prom, 32'd1, result_async, result_ack, 8'h00, 4'hc, 1'b0},
		'{cmd_pwron_read, 32'd0, result_async, result_ack, 8'h48, 4'h0, 1'b1},
		'{cmd_pwron_read, 32'd0, result_async, result_nack, 8'h48, 4'h0, 1'b0},
		'{cmd_pwroff, 32'd0, result_async, result_ack, 8'h00, 4'hc, 1'b1},
		'{cmd_config_prom, 32'd0, result_async, result_ack, 8'h00, 4'hc, 1'b0},
		'{cmd_pwron_read, 32'd1, result_async, result_ack, 8'ha0, 4'h1, 1'b1},
		'{cmd_pwroff, 32'd0, result_async, result_ack, 8'h00, 4'hc, 1'b1}
	};

	logic       clk12m;
	logic       sense_reset;
	host_byte_t rx_data;
	logic       rx_seq;
	logic       tx_ack;
	logic       rx_ack;
	host_byte_t tx_data;
	logic       tx_seq;
	rails_t     rails;
	prom_pins_t pins;

	integer seed = 32'hebca;
	int     cycle_count = 0;
	int     timeout_limit = 0;

	prom_programmer_top uut (
		.clk12m, .sense_reset,
		.rx_data, .rx_seq, .tx_ack,
		.rx_ack, .tx_data, .tx_seq, .rails, .pins
	);

	initial begin
		clk12m = 1'b0;
		forever #4 clk12m = !clk12m;
	end

	always @(posedge clk12m) begin
		cycle_count = cycle_count + 1;
		if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("Something failed");
			$fatal(1, "no progress from the DUT");
		end
	end

	// ------------------------------------------------------------
	// checks.
	// ------------------------------------------------------------
	task automatic check_byte(input string name, input host_byte_t got, input host_byte_t exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, got);
			$display("Something failed");
			$fatal(1, "wrong byte");
		end
	endtask

	task automatic check_rails(input rails_t got, input rails_t exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: rails expected %h, got %h", $time, exp, got);
			$display("Something failed");
			$fatal(1, "wrong rails");
		end
	endtask

	task automatic check_pins(input prom_pins_t got, input prom_pins_t exp);
		if (got !== exp) begin
			$display("Fail at %0d ns: pins expected %b, got %b", $time, exp, got);
			$display("Something failed");
			$fatal(1, "wrong pins");
		end
	endtask

	// ------------------------------------------------------------
	// host byte model.
	// ------------------------------------------------------------
	task automatic apply_reset();
		@(posedge clk12m);
		#1;
		sense_reset = 1'b1;
		tx_ack = 1'b0;
		repeat (8) @(posedge clk12m);
		#1;
		sense_reset = 1'b0;
	endtask

	task automatic send_byte(input host_byte_t b);
		rx_data = b;
		rx_seq = !rx_seq;
		while (rx_ack != rx_seq) begin
			@(posedge clk12m);
			#1;
		end
	endtask

	task automatic recv_byte(output host_byte_t b);
		int delay;
		while (tx_seq == tx_ack) begin
			@(posedge clk12m);
			#1;
		end
		b = tx_data;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) begin
			@(posedge clk12m);
			#1;
		end
		tx_ack = tx_seq;
	endtask

	// arguments go out least significant byte first.
	task automatic send_frame(input host_byte_t cmd, input logic [31:0] arg);
		send_byte(sof);
		send_byte(cmd);
		send_byte(arg[7:0]);
		send_byte(arg[15:8]);
		send_byte(arg[23:16]);
		send_byte(arg[31:24]);
	endtask

	task automatic poll_until_done(input logic expect_busy, output host_byte_t reply);
		logic first;
		first = 1'b1;
		do begin
			send_frame(cmd_poll, 32'h0);
			recv_byte(reply);
			if (first && expect_busy)
				check_byte("tx_data on first poll", reply, result_busy);
			first = 1'b0;
		end while (reply == result_busy);
	endtask

	function automatic int run_length_limit();
		int total;
		total = 0;
		for (int i = 0; i < n_rows; i++) begin
			if (rows[i].cmd == cmd_pwron_read)
				total = total + int'(step_read_done);
			else if (rows[i].cmd == cmd_pwroff)
				total = total + int'(step_pwroff_done);
		end
		// the interrupted power-on at the end counts as a full one.
		total = total + int'(step_read_done);
		// a command and a poll per row, then three frames around the reset.
		return (total * 3) / 2 + 200 * (2 * n_rows + 3);
	endfunction

	initial begin
		host_byte_t reply;
		sense_reset = 1'b1;
		rx_data = '0;
		rx_seq = 1'b0;
		tx_ack = 1'b0;
		timeout_limit = run_length_limit();
		apply_reset();
		check_rails(rails, 8'h00);
		check_pins(pins, 4'hc);

		// stray bytes ahead of the first frame.
		send_byte(8'h55);
		send_byte(cmd_poll);
		send_byte(8'h00);

		for (int i = 0; i < n_rows; i++) begin
			send_frame(rows[i].cmd, rows[i].arg);
			recv_byte(reply);
			check_byte("tx_data", reply, rows[i].reply);
			poll_until_done(rows[i].long_job, reply);
			check_byte("tx_data after poll", reply, rows[i].poll);
			check_rails(rails, rows[i].rails);
			check_pins(pins, rows[i].pins);
		end

		// reset in the middle of a power-on, once the read rails are up.
		send_frame(cmd_pwron_read, 32'h0);
		recv_byte(reply);
		check_byte("tx_data", reply, result_async);
		repeat (int'(step_rails_on) + 4) begin
			@(posedge clk12m);
			#1;
		end
		check_rails(rails, 8'ha0);
		send_frame(cmd_poll, 32'h0);
		recv_byte(reply);
		check_byte("tx_data on first poll", reply, result_busy);
		apply_reset();
		check_rails(rails, 8'h00);
		check_pins(pins, 4'hc);
		send_frame(cmd_poll, 32'h0);
		recv_byte(reply);
		check_byte("tx_data after reset", reply, result_nack);

		$display("Everything OK");
		$finish;
	end

endmodule
